// File: exec_macros.svh
`ifndef EXEC_MACROS_SVH
`define EXEC_MACROS_SVH

// Data path word width.
`define EXEC_WORD_W 32

// Register number width, 32 architectural registers.
`define EXEC_REG_ID_W 5

// Multiplier bits retired per cycle. Must divide the word width.
`define EXEC_MUL_BITS 4

`endif

// File: exec_types_pkg.sv
`include "exec_macros.svh"

package exec_types_pkg;

    // One data word of the integer path.
    typedef logic [`EXEC_WORD_W-1:0] word_t;

    // Register number. Register 0 reads as zero and is never a forwarding source.
    typedef logic [`EXEC_REG_ID_W-1:0] reg_id_t;

    typedef logic [4:0] shamt_t; // Enough for any shift of a word.

    typedef logic [15:0] imm_t;

    // One enable per byte lane, bit n is lane n, little-endian.
    typedef logic [`EXEC_WORD_W/8-1:0] byte_en_t;

endpackage

// File: exec_op_pkg.sv
package exec_op_pkg;

    typedef enum logic [4:0] {
        NOP, ADD, ADDU, SUB, SUBU, AND, OR, XOR, NOR, SLT, SLTU, SLL, SRL, SRA, LUI, ADDI,
        CLO, CLZ, MUL,
        LW, LH, LHU, LB, LBU, SW, SH, SB, LL, SC
    } op_e;

    typedef enum logic [1:0] {
        IDLE,
        RUN,
        DONE
    } mul_state_e;

    function automatic logic is_load(op_e op);
        return op inside {LW, LH, LHU, LB, LBU, LL};
    endfunction

    function automatic logic is_store(op_e op);
        return op inside {SW, SH, SB, SC};
    endfunction

    function automatic logic is_mul(op_e op);
        return op == MUL;
    endfunction

endpackage

// File: exec_bundle_if.sv
`timescale 1ns/1ps

interface exec_bundle_if;
    import exec_types_pkg::*;
    import exec_op_pkg::*;

    logic fire; // High on the edge where decode hands over an instruction.
    op_e op;
    word_t src_a;
    word_t src_b;
    imm_t imm;
    shamt_t shamt;
    reg_id_t dest;
    logic wr_en;

    modport issue (output fire, op, src_a, src_b, imm, shamt, dest, wr_en);

    modport alu (input op, src_a, src_b, imm, shamt);

    modport mul (input src_a, src_b);

    modport retire (input fire, op, src_b, dest, wr_en);

endinterface

// File: operand_bypass.sv
`timescale 1ns/1ps

module operand_bypass (
    input logic Clk,
    input logic reset,
    input logic dec_valid,
    input exec_op_pkg::op_e dec_op,
    input exec_types_pkg::reg_id_t dec_rs,
    input exec_types_pkg::reg_id_t dec_rt,
    input exec_types_pkg::reg_id_t dec_dest,
    input exec_types_pkg::word_t dec_rs_data,
    input exec_types_pkg::word_t dec_rt_data,
    input exec_types_pkg::imm_t dec_imm,
    input exec_types_pkg::shamt_t dec_shamt,
    input logic dec_wr_en,
    input logic m_wr_en,
    input exec_types_pkg::reg_id_t m_reg,
    input exec_types_pkg::word_t m_data,
    input logic fwd_wr_en,
    input exec_types_pkg::reg_id_t fwd_reg,
    input exec_types_pkg::word_t fwd_data,
    input logic stage_ready,
    output logic exec_ready,
    exec_bundle_if.issue bundle
);
    import exec_types_pkg::*;
    import exec_op_pkg::*;

    word_t rs_value;
    word_t rt_value;
    logic rt_is_src;

    // The stage's own result register is younger than the memory stage, so it wins.
    assign rs_value = (dec_rs != '0 && fwd_wr_en && dec_rs == fwd_reg) ? fwd_data :
                      (dec_rs != '0 && m_wr_en && dec_rs == m_reg) ? m_data : dec_rs_data;
    assign rt_value = (dec_rt != '0 && fwd_wr_en && dec_rt == fwd_reg) ? fwd_data :
                      (dec_rt != '0 && m_wr_en && dec_rt == m_reg) ? m_data : dec_rt_data;

    assign rt_is_src = !is_load(dec_op); // For loads rt names the destination.

    assign exec_ready = stage_ready;
    assign bundle.fire = dec_valid && stage_ready;
    assign bundle.op = bundle.fire ? dec_op : NOP;
    assign bundle.src_a = rs_value;
    assign bundle.src_b = rt_is_src ? rt_value : '0;
    assign bundle.imm = dec_imm;
    assign bundle.shamt = dec_shamt;
    assign bundle.dest = dec_dest;
    assign bundle.wr_en = bundle.fire && dec_wr_en;

    // Register 0 must reach the ALU straight from the register file, whatever retire reports.
    assert property (@(posedge Clk) disable iff (reset)
        bundle.fire && dec_rs == '0 |-> bundle.src_a == dec_rs_data);

endmodule

// File: exec_alu.sv
`timescale 1ns/1ps

module exec_alu (
    exec_bundle_if.alu bundle,
    output exec_types_pkg::word_t result,
    output exec_types_pkg::word_t addr,
    output logic overflow
);
    import exec_types_pkg::*;
    import exec_op_pkg::*;

    localparam int MSB = $bits(word_t) - 1;

    word_t a;
    word_t b;
    word_t imm_sext;
    word_t sum;
    word_t diff;
    word_t imm_sum;
    logic lead_bit;
    logic [5:0] lead_count;

    assign a = bundle.src_a;
    assign b = bundle.src_b;
    assign imm_sext = word_t'(signed'(bundle.imm));
    assign sum = a + b;
    assign diff = a - b;
    assign imm_sum = a + imm_sext;

    assign addr = (is_load(bundle.op) || is_store(bundle.op)) ? imm_sum : '0;

    // CLO counts ones, CLZ counts zeros, both from the top bit down.
    assign lead_bit = (bundle.op == CLO);

    always_comb begin
        lead_count = 6'($bits(word_t));
        for (int i = 0; i <= MSB; i++) begin
            if (a[i] != lead_bit) begin
                lead_count = 6'(MSB - i); // The highest mismatch is written last.
            end
        end
    end

    always_comb begin
        case (bundle.op)
            ADD, ADDU: result = sum;
            SUB, SUBU: result = diff;
            AND:       result = a & b;
            OR:        result = a | b;
            XOR:       result = a ^ b;
            NOR:       result = ~(a | b);
            SLT:       result = word_t'($signed(a) < $signed(b));
            SLTU:      result = word_t'(a < b);
            SLL:       result = b << bundle.shamt;
            SRL:       result = b >> bundle.shamt;
            SRA:       result = word_t'($signed(b) >>> bundle.shamt);
            LUI:       result = {bundle.imm, 16'h0000};
            ADDI:      result = imm_sum;
            CLO, CLZ:  result = word_t'(lead_count);
            default:   result = addr; // Memory ops carry the address, the rest give zero.
        endcase
    end

    // Signed overflow only for the trapping forms.
    always_comb begin
        case (bundle.op)
            ADD:     overflow = (a[MSB] == b[MSB]) && (sum[MSB] != a[MSB]);
            SUB:     overflow = (a[MSB] != b[MSB]) && (diff[MSB] != a[MSB]);
            ADDI:    overflow = (a[MSB] == imm_sext[MSB]) && (imm_sum[MSB] != a[MSB]);
            default: overflow = 1'b0;
        endcase
    end

endmodule

// File: mul_unit.sv
`timescale 1ns/1ps
`include "exec_macros.svh"

module mul_unit #(
    parameter int BITS_PER_CYCLE = `EXEC_MUL_BITS
) (
    input logic Clk,
    input logic reset,
    input logic flush,
    input logic start,
    exec_bundle_if.mul bundle,
    output logic busy,
    output logic done,
    output exec_types_pkg::word_t lo
);
    import exec_types_pkg::*;
    import exec_op_pkg::*;

    localparam int STEPS = $bits(word_t) / BITS_PER_CYCLE;
    localparam int CNT_W = $clog2(STEPS);

    mul_state_e state;
    logic [CNT_W-1:0] count;
    word_t mcand;
    word_t mplier;
    word_t acc;

    always_ff @(posedge Clk) begin
        if (reset || flush) begin
            state <= IDLE;
            count <= '0;
        end else begin
            case (state)
                IDLE: if (start) state <= RUN;
                RUN: begin
                    count <= count + 1'b1;
                    if (count == CNT_W'(STEPS - 1)) state <= DONE;
                end
                DONE: begin
                    state <= IDLE; // Done is a single-cycle pulse.
                    count <= '0;
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Radix 2^BITS shift-add, only the low word of the product is kept.
    always_ff @(posedge Clk) begin
        if (state == IDLE && start) begin
            mcand <= bundle.src_a;
            mplier <= bundle.src_b;
            acc <= '0;
        end else if (state == RUN) begin
            acc <= acc + mcand * mplier[BITS_PER_CYCLE-1:0];
            mcand <= mcand << BITS_PER_CYCLE;
            mplier <= mplier >> BITS_PER_CYCLE;
        end
    end

    assign busy = (state == RUN);
    assign done = (state == DONE);
    assign lo = acc;

    assert property (@(posedge Clk) disable iff (reset) done |-> $past(busy));

endmodule

// File: exec_retire.sv
`timescale 1ns/1ps

module exec_retire (
    input logic Clk,
    input logic reset,
    input logic flush,
    input logic mem_stall,
    exec_bundle_if.retire bundle,
    input exec_types_pkg::word_t alu_result,
    input exec_types_pkg::word_t alu_addr,
    input logic alu_overflow,
    input logic mul_busy,
    input logic mul_done,
    input exec_types_pkg::word_t mul_lo,
    output logic mul_start,
    output logic stage_ready,
    output logic fwd_wr_en,
    output exec_types_pkg::reg_id_t fwd_reg,
    output exec_types_pkg::word_t fwd_data,
    output logic res_valid,
    output exec_types_pkg::reg_id_t res_reg,
    output logic res_wr_en,
    output exec_types_pkg::word_t res_data,
    output logic mem_read,
    output logic mem_write,
    output exec_types_pkg::word_t mem_addr,
    output exec_types_pkg::byte_en_t mem_be,
    output exec_types_pkg::word_t mem_wdata,
    output logic exc_overflow,
    output logic exc_unaligned
);
    import exec_types_pkg::*;
    import exec_op_pkg::*;

    logic res_new;
    logic link;
    logic park_valid;
    logic park_done;
    logic park_wr_en;
    reg_id_t park_dest;
    word_t park_lo;
    logic park_take;
    logic alu_take;
    logic [1:0] offset;
    logic unaligned;
    byte_en_t be_raw;
    byte_en_t be_next;
    word_t wdata_next;
    word_t data_next;

    assign mul_start = bundle.fire && is_mul(bundle.op) && !flush;
    assign park_take = park_valid && park_done && !mem_stall;
    assign alu_take = bundle.fire && !is_mul(bundle.op);
    assign stage_ready = !park_valid && !mem_stall; // One multiply in flight at most.

    assign offset = alu_addr[1:0];
    assign unaligned = (bundle.op inside {LW, LL, SW, SC} && offset != 2'b00) ||
                       (bundle.op inside {LH, LHU, SH} && offset[0]);

    always_comb begin
        case (bundle.op)
            SW, SC: begin
                be_raw = 4'b1111;
                wdata_next = bundle.src_b;
            end
            SH: begin
                be_raw = 4'b0011 << offset;
                wdata_next = {2{bundle.src_b[15:0]}};
            end
            SB: begin
                be_raw = 4'b0001 << offset;
                wdata_next = {4{bundle.src_b[7:0]}};
            end
            default: begin
                be_raw = '0;
                wdata_next = bundle.src_b;
            end
        endcase
    end

    assign be_next = (unaligned || (bundle.op == SC && !link)) ? '0 : be_raw;
    assign data_next = (bundle.op == SC) ? word_t'(link) : alu_result;

    always_ff @(posedge Clk) begin
        if (reset) begin
            res_new <= 1'b0;
            res_wr_en <= 1'b0;
            mem_read <= 1'b0;
            mem_write <= 1'b0;
            mem_be <= '0;
            exc_overflow <= 1'b0;
            exc_unaligned <= 1'b0;
            park_valid <= 1'b0;
            park_done <= 1'b0;
            link <= 1'b0;
        end else begin
            if (bundle.fire && !flush) begin
                if (bundle.op == LL) link <= 1'b1;
                else if (bundle.op == SC) link <= 1'b0;
            end
            if (flush) begin
                park_valid <= 1'b0;
                park_done <= 1'b0;
            end else if (mul_start) begin
                park_valid <= 1'b1;
                park_done <= 1'b0;
            end else if (park_take) begin
                park_valid <= 1'b0;
                park_done <= 1'b0;
            end else if (mul_done) begin
                park_done <= 1'b1; // Held here in case the memory stage stalls.
            end
            if (flush || (!mem_stall && !park_take && !alu_take)) begin
                res_new <= 1'b0;
                res_wr_en <= 1'b0;
                mem_read <= 1'b0;
                mem_write <= 1'b0;
                mem_be <= '0;
                exc_overflow <= 1'b0;
                exc_unaligned <= 1'b0;
            end else if (park_take) begin
                res_new <= 1'b1;
                res_wr_en <= park_wr_en;
                mem_read <= 1'b0;
                mem_write <= 1'b0;
                mem_be <= '0;
                exc_overflow <= 1'b0;
                exc_unaligned <= 1'b0;
            end else if (alu_take) begin
                res_new <= 1'b1;
                res_wr_en <= bundle.wr_en && !alu_overflow;
                mem_read <= is_load(bundle.op) && !unaligned;
                mem_write <= is_store(bundle.op) && !unaligned;
                mem_be <= be_next;
                exc_overflow <= alu_overflow;
                exc_unaligned <= unaligned;
            end
        end
    end

    always_ff @(posedge Clk) begin
        if (mul_start) begin
            park_dest <= bundle.dest;
            park_wr_en <= bundle.wr_en;
        end
        if (mul_done) park_lo <= mul_lo;
        if (park_take) begin
            res_reg <= park_dest;
            res_data <= park_lo;
        end else if (alu_take && !mem_stall) begin
            res_reg <= bundle.dest;
            res_data <= data_next;
            mem_addr <= alu_addr;
            mem_wdata <= wdata_next;
        end
    end

    assign res_valid = res_new && !mem_stall;

    // A load's data is not known here, so only computed results are forwarded.
    assign fwd_wr_en = res_new && res_wr_en && !mem_read;
    assign fwd_reg = res_reg;
    assign fwd_data = res_data;

    assert property (@(posedge Clk) disable iff (reset) !(mem_read && mem_write));

    // The multiplier only runs for an instruction that is parked here.
    assert property (@(posedge Clk) disable iff (reset) mul_busy |-> park_valid);

endmodule

// File: exec_stage.sv
`timescale 1ns/1ps

module exec_stage (
    input logic Clk,
    input logic reset,
    input logic flush,
    input logic mem_stall,
    input logic dec_valid,
    input exec_op_pkg::op_e dec_op,
    input exec_types_pkg::reg_id_t dec_rs,
    input exec_types_pkg::reg_id_t dec_rt,
    input exec_types_pkg::reg_id_t dec_dest,
    input exec_types_pkg::word_t dec_rs_data,
    input exec_types_pkg::word_t dec_rt_data,
    input exec_types_pkg::imm_t dec_imm,
    input exec_types_pkg::shamt_t dec_shamt,
    input logic dec_wr_en,
    input logic m_wr_en,
    input exec_types_pkg::reg_id_t m_reg,
    input exec_types_pkg::word_t m_data,
    output logic exec_ready,
    output logic res_valid,
    output exec_types_pkg::reg_id_t res_reg,
    output logic res_wr_en,
    output exec_types_pkg::word_t res_data,
    output logic mem_read,
    output logic mem_write,
    output exec_types_pkg::word_t mem_addr,
    output exec_types_pkg::byte_en_t mem_be,
    output exec_types_pkg::word_t mem_wdata,
    output logic exc_overflow,
    output logic exc_unaligned
);
    import exec_types_pkg::*;

    exec_bundle_if bundle ();

    word_t alu_result;
    word_t alu_addr;
    logic alu_overflow;
    logic mul_start;
    logic mul_busy;
    logic mul_done;
    word_t mul_lo;
    logic fwd_wr_en;
    reg_id_t fwd_reg;
    word_t fwd_data;
    logic stage_ready;

    operand_bypass u_bypass (
        .Clk(Clk), .reset(reset),
        .dec_valid(dec_valid), .dec_op(dec_op), .dec_rs(dec_rs), .dec_rt(dec_rt),
        .dec_dest(dec_dest), .dec_rs_data(dec_rs_data), .dec_rt_data(dec_rt_data),
        .dec_imm(dec_imm), .dec_shamt(dec_shamt), .dec_wr_en(dec_wr_en),
        .m_wr_en(m_wr_en), .m_reg(m_reg), .m_data(m_data),
        .fwd_wr_en(fwd_wr_en), .fwd_reg(fwd_reg), .fwd_data(fwd_data),
        .stage_ready(stage_ready), .exec_ready(exec_ready), .bundle(bundle.issue)
    );

    exec_alu u_alu (
        .bundle(bundle.alu), .result(alu_result), .addr(alu_addr), .overflow(alu_overflow)
    );

    mul_unit u_mul (
        .Clk(Clk), .reset(reset), .flush(flush), .start(mul_start), .bundle(bundle.mul),
        .busy(mul_busy), .done(mul_done), .lo(mul_lo)
    );

    exec_retire u_retire (
        .Clk(Clk), .reset(reset), .flush(flush), .mem_stall(mem_stall),
        .bundle(bundle.retire),
        .alu_result(alu_result), .alu_addr(alu_addr), .alu_overflow(alu_overflow),
        .mul_busy(mul_busy), .mul_done(mul_done), .mul_lo(mul_lo), .mul_start(mul_start),
        .stage_ready(stage_ready),
        .fwd_wr_en(fwd_wr_en), .fwd_reg(fwd_reg), .fwd_data(fwd_data),
        .res_valid(res_valid), .res_reg(res_reg), .res_wr_en(res_wr_en),
        .res_data(res_data), .mem_read(mem_read), .mem_write(mem_write),
        .mem_addr(mem_addr), .mem_be(mem_be), .mem_wdata(mem_wdata),
        .exc_overflow(exc_overflow), .exc_unaligned(exc_unaligned)
    );

endmodule

// File: exec_stage_tb.sv
`timescale 1ns/1ps

module exec_stage_tb;
    import exec_types_pkg::*;
    import exec_op_pkg::*;

    localparam int MAX_LINES = 64;
    localparam int NUM_COLS = 22;

    logic Clk;
    logic reset;
    logic flush;
    logic mem_stall;
    logic dec_valid;
    op_e dec_op;
    reg_id_t dec_rs;
    reg_id_t dec_rt;
    reg_id_t dec_dest;
    word_t dec_rs_data;
    word_t dec_rt_data;
    imm_t dec_imm;
    shamt_t dec_shamt;
    logic dec_wr_en;
    logic m_wr_en;
    reg_id_t m_reg;
    word_t m_data;
    logic exec_ready;
    logic res_valid;
    reg_id_t res_reg;
    logic res_wr_en;
    word_t res_data;
    logic mem_read;
    logic mem_write;
    word_t mem_addr;
    byte_en_t mem_be;
    word_t mem_wdata;
    logic exc_overflow;
    logic exc_unaligned;

    // One row per golden line, columns in file order.
    logic [31:0] vectors [MAX_LINES][NUM_COLS];
    int num_lines;
    int pending[$]; // Line numbers issued and not yet retired.
    int check_errors;
    int cycles;
    int line_idx;
    int flushed_idx;
    logic accepted;

    exec_stage uut (.*);

    initial begin
        Clk = 1'b0;
        forever #50 Clk = ~Clk;
    end

    task automatic stop_with_failure();
        $display("Result: FAILED");
        $fatal(1);
    endtask

    task automatic check_value(string name, logic [31:0] got, logic [31:0] expected);
        if (got !== expected) begin
            check_errors++;
            $display("CHECK FAILED %s: got 0x%h, expected 0x%h", name, got, expected);
            stop_with_failure();
        end
    endtask

    task automatic load_vectors();
        int fd;
        int count;
        string text;
        logic [31:0] v [NUM_COLS];
        fd = $fopen("exec_stage_golden.txt", "r");
        if (fd == 0) begin
            $display("Could not open exec_stage_golden.txt");
            stop_with_failure();
        end
        num_lines = 0;
        while (!$feof(fd)) begin
            text = "";
            void'($fgets(text, fd));
            count = $sscanf(text,
                "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7], v[8], v[9], v[10],
                v[11], v[12], v[13], v[14], v[15], v[16], v[17], v[18], v[19], v[20],
                v[21]);
            if (count == NUM_COLS) begin // Comment and blank lines give no match.
                if (num_lines == MAX_LINES) begin
                    $display("Golden file has more lines than the testbench can hold");
                    stop_with_failure();
                end
                for (int c = 0; c < NUM_COLS; c++) begin
                    vectors[num_lines][c] = v[c];
                end
                num_lines++;
            end
        end
        $fclose(fd);
    endtask

    task automatic drive_line(int k);
        dec_valid <= 1'b1;
        dec_op <= op_e'(vectors[k][1][4:0]);
        dec_rs <= reg_id_t'(vectors[k][2]);
        dec_rt <= reg_id_t'(vectors[k][3]);
        dec_dest <= reg_id_t'(vectors[k][4]);
        dec_rs_data <= vectors[k][5];
        dec_rt_data <= vectors[k][6];
        dec_imm <= imm_t'(vectors[k][7]);
        dec_shamt <= shamt_t'(vectors[k][8]);
        dec_wr_en <= vectors[k][9][0];
        m_wr_en <= vectors[k][10][0];
        m_reg <= reg_id_t'(vectors[k][11]);
        m_data <= vectors[k][12];
    endtask

    task automatic drive_idle();
        dec_valid <= 1'b0;
        dec_op <= NOP;
        m_wr_en <= 1'b0;
    endtask

    task automatic check_result();
        int k;
        word_t addr_expected;
        if (pending.size() == 0) begin
            $display("A result appeared with no instruction outstanding");
            stop_with_failure();
        end
        k = pending.pop_front();
        check_value("res_reg", 32'(res_reg), vectors[k][13]);
        check_value("res_wr_en", 32'(res_wr_en), vectors[k][14]);
        check_value("res_data", res_data, vectors[k][15]);
        check_value("mem_read", 32'(mem_read), vectors[k][16]);
        check_value("mem_write", 32'(mem_write), vectors[k][17]);
        check_value("mem_be", 32'(mem_be), vectors[k][18]);
        check_value("exc_overflow", 32'(exc_overflow), vectors[k][20]);
        check_value("exc_unaligned", 32'(exc_unaligned), vectors[k][21]);
        if (vectors[k][17][0]) begin
            check_value("mem_wdata", mem_wdata, vectors[k][19]); // Only stores carry data.
        end
        if (vectors[k][16][0] || vectors[k][17][0] || vectors[k][21][0]) begin
            // A memory row takes its base straight from the register file.
            addr_expected = vectors[k][5] + {{16{vectors[k][7][15]}}, vectors[k][7][15:0]};
            check_value("mem_addr", mem_addr, addr_expected);
        end
    endtask

    initial begin
        reset = 1'b1;
        flush = 1'b0;
        mem_stall = 1'b0;
        dec_valid = 1'b0;
        dec_op = NOP;
        dec_rs = '0;
        dec_rt = '0;
        dec_dest = '0;
        dec_rs_data = '0;
        dec_rt_data = '0;
        dec_imm = '0;
        dec_shamt = '0;
        dec_wr_en = 1'b0;
        m_wr_en = 1'b0;
        m_reg = '0;
        m_data = '0;
        check_errors = 0;
        cycles = 0;
        line_idx = 0;
        flushed_idx = -1;
        accepted = 1'b0;
        void'($urandom(32'hfd09));
        load_vectors();

        repeat (8) @(posedge Clk);
        reset <= 1'b0;
        @(negedge Clk);
        check_value("res_valid", 32'(res_valid), 32'h0);
        check_value("exec_ready", 32'(exec_ready), 32'h1);

        while (line_idx < num_lines || pending.size() != 0) begin
            @(posedge Clk);
            if (accepted) line_idx++;
            mem_stall <= ($urandom % 4) == 0;
            flush <= 1'b0;
            if (line_idx >= num_lines) begin
                drive_idle();
            end else if (vectors[line_idx][0][0] && flushed_idx != line_idx) begin
                drive_idle(); // The flush waits until everything has retired.
                if (pending.size() == 0) begin
                    flush <= 1'b1;
                    flushed_idx = line_idx;
                end
            end else begin
                drive_line(line_idx);
            end

            @(negedge Clk);
            accepted = dec_valid && exec_ready;
            if (accepted) pending.push_back(line_idx);
            if (res_valid) check_result();
            cycles++;
            if (cycles > num_lines * 12 + 50) begin
                $display("Timeout after %0d cycles with %0d results missing", cycles,
                         pending.size());
                stop_with_failure();
            end
        end

        if (pending.size() == 0 && check_errors == 0) begin
            $display("Result: PASSED");
            $finish;
        end else begin
            stop_with_failure();
        end
    end

endmodule

// File: exec_stage_golden.txt
# Inputs: flush op rs rt dest rs_data rt_data imm shamt wr_en m_wr_en m_reg m_data
# Expected: reg wr_en data mem_read mem_write be wdata overflow unaligned (all hex)
0 1 2 3 1 00001000 00000234 0000 0 1 0 0 00000000 1 1 00001234 0 0 0 00000000 0 0
0 3 1 5 4 00000000 00000034 0000 0 1 0 0 00000000 4 1 00001200 0 0 0 00000000 0 0
0 5 7 8 6 ff00ff00 0f0f0f0f 0000 0 1 0 0 00000000 6 1 0f000f00 0 0 0 00000000 0 0
0 6 a b 9 12340000 00005678 0000 0 1 0 0 00000000 9 1 12345678 0 0 0 00000000 0 0
0 7 d e c ffff0000 0f0f0f0f 0000 0 1 0 0 00000000 c 1 f0f00f0f 0 0 0 00000000 0 0
0 8 10 11 f 00ff00ff 0f000000 0000 0 1 0 0 00000000 f 1 f000ff00 0 0 0 00000000 0 0
0 9 13 14 12 ffffffff 00000001 0000 0 1 0 0 00000000 12 1 00000001 0 0 0 00000000 0 0
0 a 16 17 15 ffffffff 00000001 0000 0 1 0 0 00000000 15 1 00000000 0 0 0 00000000 0 0
0 b 0 19 18 00000000 00000081 0000 4 1 0 0 00000000 18 1 00000810 0 0 0 00000000 0 0
0 d 0 1b 1a 00000000 80000000 0000 8 1 0 0 00000000 1a 1 ff800000 0 0 0 00000000 0 0
0 c 0 1d 1c 00000000 80000000 0000 1f 1 0 0 00000000 1c 1 00000001 0 0 0 00000000 0 0
0 e 0 0 1e 00000000 00000000 beef 0 1 0 0 00000000 1e 1 beef0000 0 0 0 00000000 0 0
0 11 2 0 1 00010000 00000000 0000 0 1 0 0 00000000 1 1 0000000f 0 0 0 00000000 0 0
0 10 4 0 3 fff00000 00000000 0000 0 1 0 0 00000000 3 1 0000000c 0 0 0 00000000 0 0
0 1 6 7 5 7fffffff 00000001 0000 0 1 0 0 00000000 5 0 80000000 0 0 0 00000000 1 0
0 2 5 8 0 00000010 00000005 0000 0 1 0 0 00000000 0 1 00000015 0 0 0 00000000 0 0
0 2 0 a 9 00000000 00000003 0000 0 1 1 0 deadbeef 9 1 00000003 0 0 0 00000000 0 0
0 2 c d b 00000000 00000011 0000 0 1 1 c 00000100 b 1 00000111 0 0 0 00000000 0 0
0 4 b d e 00000000 00000011 0000 0 1 1 b 0000ffff e 1 00000100 0 0 0 00000000 0 0
0 12 10 11 f 00012345 00000103 0000 0 1 0 0 00000000 f 1 0126aecf 0 0 0 00000000 0 0
0 2 f 13 12 00000000 00000001 0000 0 1 0 0 00000000 12 1 0126aed0 0 0 0 00000000 0 0
0 12 15 16 14 ffffffff 00000003 0000 0 1 0 0 00000000 14 1 fffffffd 0 0 0 00000000 0 0
0 2 18 19 17 00000001 00000002 0000 0 1 0 0 00000000 17 1 00000003 0 0 0 00000000 0 0
1 1b 2 1 1 00001000 00000000 0010 0 1 0 0 00000000 1 1 00001010 1 0 0 00000000 0 0
0 1c 4 3 3 00001000 11223344 0010 0 1 0 0 00000000 3 1 00000001 0 1 f 11223344 0 0
0 1c 4 5 5 00001000 55667788 0014 0 1 0 0 00000000 5 1 00000000 0 1 0 55667788 0 0
0 18 6 7 0 00002000 a5a5a5a5 0004 0 0 0 0 00000000 0 0 00002004 0 1 f a5a5a5a5 0 0
0 19 8 a 0 00002000 0000beef 0006 0 0 0 0 00000000 0 0 00002006 0 1 c beefbeef 0 0
0 1a b c 0 00002000 12345678 0003 0 0 0 0 00000000 0 0 00002003 0 1 8 78787878 0 0
0 18 d e 0 00002000 00000000 0002 0 0 0 0 00000000 0 0 00002002 0 0 0 00000000 0 1
0 14 f 10 10 00002000 00000000 0001 0 1 0 0 00000000 10 1 00002001 0 0 0 00000000 0 1
0 17 11 12 12 00003000 00000000 0003 0 1 0 0 00000000 12 1 00003003 1 0 0 00000000 0 0
0 f 13 0 14 00000100 00000000 fff0 0 1 0 0 00000000 14 1 000000f0 0 0 0 00000000 0 0
0 13 15 16 16 00001000 00000000 fffc 0 1 0 0 00000000 16 1 00000ffc 1 0 0 00000000 0 0

// File: exec_stage.f
+incdir+.
exec_types_pkg.sv
exec_op_pkg.sv
exec_bundle_if.sv
operand_bypass.sv
exec_alu.sv
mul_unit.sv
exec_retire.sv
exec_stage.sv
exec_stage_tb.sv

// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal -f exec_stage.f --top-module exec_stage_tb -o sim_exec_stage
	./obj_dir/sim_exec_stage

clean:
	rm -rf obj_dir
